// File: design/defs_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 widths, response code and the
// arbiter and controller state enums
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package defs_pkg;

  localparam int AxiIdW   = 4;
  localparam int AxiAddrW = 32;
  localparam int AxiDataW = 64;
  localparam int AxiStrbW = 8;
  localparam int AxiLenW  = 8;

  localparam logic [1:0] RespOkay = 2'b00;

  // Per-direction grant of the arbiter
  typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_t;

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;

  typedef enum logic {RD_IDLE, RD_BURST} rd_state_t;

endpackage

// File: design/axi_arbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin AXI4 arbiter, NM managers
// onto one subordinate, read/write apart
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module axi_arbiter #(
  parameter int NM = 2
) (
  input  logic                              clk,
  input  logic                              rst_n,
  // Managers, slice i belongs to manager i
  input  logic [NM*defs_pkg::AxiIdW-1:0]   s_awid,
  input  logic [NM*defs_pkg::AxiAddrW-1:0] s_awaddr,
  input  logic [NM*defs_pkg::AxiLenW-1:0]  s_awlen,
  input  logic [NM-1:0]                    s_awvalid,
  output logic [NM-1:0]                    s_awready,
  input  logic [NM*defs_pkg::AxiDataW-1:0] s_wdata,
  input  logic [NM*defs_pkg::AxiStrbW-1:0] s_wstrb,
  input  logic [NM-1:0]                    s_wlast,
  input  logic [NM-1:0]                    s_wvalid,
  output logic [NM-1:0]                    s_wready,
  output logic [NM*defs_pkg::AxiIdW-1:0]   s_bid,
  output logic [NM*2-1:0]                  s_bresp,
  output logic [NM-1:0]                    s_bvalid,
  input  logic [NM-1:0]                    s_bready,
  input  logic [NM*defs_pkg::AxiIdW-1:0]   s_arid,
  input  logic [NM*defs_pkg::AxiAddrW-1:0] s_araddr,
  input  logic [NM*defs_pkg::AxiLenW-1:0]  s_arlen,
  input  logic [NM-1:0]                    s_arvalid,
  output logic [NM-1:0]                    s_arready,
  output logic [NM*defs_pkg::AxiIdW-1:0]   s_rid,
  output logic [NM*defs_pkg::AxiDataW-1:0] s_rdata,
  output logic [NM*2-1:0]                  s_rresp,
  output logic [NM-1:0]                    s_rlast,
  output logic [NM-1:0]                    s_rvalid,
  input  logic [NM-1:0]                    s_rready,
  // Single subordinate
  output logic [defs_pkg::AxiIdW-1:0]      m_awid,
  output logic [defs_pkg::AxiAddrW-1:0]    m_awaddr,
  output logic [defs_pkg::AxiLenW-1:0]     m_awlen,
  output logic                             m_awvalid,
  input  logic                             m_awready,
  output logic [defs_pkg::AxiDataW-1:0]    m_wdata,
  output logic [defs_pkg::AxiStrbW-1:0]    m_wstrb,
  output logic                             m_wlast,
  output logic                             m_wvalid,
  input  logic                             m_wready,
  input  logic [defs_pkg::AxiIdW-1:0]      m_bid,
  input  logic [1:0]                       m_bresp,
  input  logic                             m_bvalid,
  output logic                             m_bready,
  output logic [defs_pkg::AxiIdW-1:0]      m_arid,
  output logic [defs_pkg::AxiAddrW-1:0]    m_araddr,
  output logic [defs_pkg::AxiLenW-1:0]     m_arlen,
  output logic                             m_arvalid,
  input  logic                             m_arready,
  input  logic [defs_pkg::AxiIdW-1:0]      m_rid,
  input  logic [defs_pkg::AxiDataW-1:0]    m_rdata,
  input  logic [1:0]                       m_rresp,
  input  logic                             m_rlast,
  input  logic                             m_rvalid,
  output logic                             m_rready
);

  import defs_pkg::*;

  localparam int IdxW = (NM > 1) ? $clog2(NM) : 1;

  arb_state_t      wr_st;
  arb_state_t      rd_st;
  logic [IdxW-1:0] wr_sel;
  logic [IdxW-1:0] rd_sel;
  logic [IdxW:0]   aw_pick;
  logic [IdxW:0]   ar_pick;
  logic            wr_on;
  logic            rd_on;

  // Nearest requester after the last winner, MSB flags a hit
  function automatic logic [IdxW:0] rr_pick(input logic [NM-1:0]   req,
                                           input logic [IdxW-1:0] last);
    logic [IdxW:0] res;
    int            idx;
    res = '0;
    for (int k = NM; k >= 1; k--) begin
      idx = (int'(last) + k) % NM;
      if (req[idx]) begin
        res = {1'b1, idx[IdxW-1:0]};
      end
    end
    return res;
  endfunction

  assign aw_pick = rr_pick(s_awvalid, wr_sel);
  assign ar_pick = rr_pick(s_arvalid, rd_sel);

  // Grant is held until B, wr_sel doubles as the last winner
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_st  <= ARB_IDLE;
      wr_sel <= '0;
    end else if (wr_st == ARB_IDLE) begin
      if (aw_pick[IdxW]) begin
        wr_st  <= ARB_BUSY;
        wr_sel <= aw_pick[IdxW-1:0];
      end
    end else if (m_bvalid && m_bready) begin
      wr_st <= ARB_IDLE;
    end
  end

  // Read grant ends with the rlast beat
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_st  <= ARB_IDLE;
      rd_sel <= '0;
    end else if (rd_st == ARB_IDLE) begin
      if (ar_pick[IdxW]) begin
        rd_st  <= ARB_BUSY;
        rd_sel <= ar_pick[IdxW-1:0];
      end
    end else if (m_rvalid && m_rready && m_rlast) begin
      rd_st <= ARB_IDLE;
    end
  end

  assign wr_on = (wr_st == ARB_BUSY);
  assign rd_on = (rd_st == ARB_BUSY);

  assign m_awid    = s_awid[wr_sel*AxiIdW +: AxiIdW];
  assign m_awaddr  = s_awaddr[wr_sel*AxiAddrW +: AxiAddrW];
  assign m_awlen   = s_awlen[wr_sel*AxiLenW +: AxiLenW];
  assign m_awvalid = wr_on && s_awvalid[wr_sel];
  assign m_wdata   = s_wdata[wr_sel*AxiDataW +: AxiDataW];
  assign m_wstrb   = s_wstrb[wr_sel*AxiStrbW +: AxiStrbW];
  assign m_wlast   = s_wlast[wr_sel];
  assign m_wvalid  = wr_on && s_wvalid[wr_sel];
  assign m_bready  = wr_on && s_bready[wr_sel];

  assign m_arid    = s_arid[rd_sel*AxiIdW +: AxiIdW];
  assign m_araddr  = s_araddr[rd_sel*AxiAddrW +: AxiAddrW];
  assign m_arlen   = s_arlen[rd_sel*AxiLenW +: AxiLenW];
  assign m_arvalid = rd_on && s_arvalid[rd_sel];
  assign m_rready  = rd_on && s_rready[rd_sel];

  // Payload goes to everyone, only the owner sees valid or ready
  assign s_bid   = {NM{m_bid}};
  assign s_bresp = {NM{m_bresp}};
  assign s_rid   = {NM{m_rid}};
  assign s_rdata = {NM{m_rdata}};
  assign s_rresp = {NM{m_rresp}};
  assign s_rlast = {NM{m_rlast}};

  always_comb begin
    s_awready         = '0;
    s_wready          = '0;
    s_bvalid          = '0;
    s_arready         = '0;
    s_rvalid          = '0;
    s_awready[wr_sel] = wr_on && m_awready;
    s_wready[wr_sel]  = wr_on && m_wready;
    s_bvalid[wr_sel]  = wr_on && m_bvalid;
    s_arready[rd_sel] = rd_on && m_arready;
    s_rvalid[rd_sel]  = rd_on && m_rvalid;
  end

endmodule

// File: design/ssram_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4 subordinate, bursts to BRAM
// port A writes and port B reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ssram_ctrl #(
  parameter int BramAw = 10
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // AXI4 subordinate
  input  logic [defs_pkg::AxiIdW-1:0]   s_awid,
  input  logic [defs_pkg::AxiAddrW-1:0] s_awaddr,
  input  logic [defs_pkg::AxiLenW-1:0]  s_awlen,
  input  logic                          s_awvalid,
  output logic                          s_awready,
  input  logic [defs_pkg::AxiDataW-1:0] s_wdata,
  input  logic [defs_pkg::AxiStrbW-1:0] s_wstrb,
  input  logic                          s_wlast,
  input  logic                          s_wvalid,
  output logic                          s_wready,
  output logic [defs_pkg::AxiIdW-1:0]   s_bid,
  output logic [1:0]                    s_bresp,
  output logic                          s_bvalid,
  input  logic                          s_bready,
  input  logic [defs_pkg::AxiIdW-1:0]   s_arid,
  input  logic [defs_pkg::AxiAddrW-1:0] s_araddr,
  input  logic [defs_pkg::AxiLenW-1:0]  s_arlen,
  input  logic                          s_arvalid,
  output logic                          s_arready,
  output logic [defs_pkg::AxiIdW-1:0]   s_rid,
  output logic [defs_pkg::AxiDataW-1:0] s_rdata,
  output logic [1:0]                    s_rresp,
  output logic                          s_rlast,
  output logic                          s_rvalid,
  input  logic                          s_rready,
  // BRAM port A
  output logic                          ena,
  output logic                          rdena,
  output logic                          wrena,
  output logic [defs_pkg::AxiStrbW-1:0] byteena,
  output logic [BramAw-1:0]             addra,
  output logic [defs_pkg::AxiDataW-1:0] dina,
  input  logic [defs_pkg::AxiDataW-1:0] douta,
  // BRAM port B
  output logic                          enb,
  output logic                          rdenb,
  output logic                          wrenb,
  output logic [defs_pkg::AxiStrbW-1:0] byteenb,
  output logic [BramAw-1:0]             addrb,
  output logic [defs_pkg::AxiDataW-1:0] dinb,
  input  logic [defs_pkg::AxiDataW-1:0] doutb
);

  import defs_pkg::*;

  wr_state_t           wr_st;
  logic [AxiIdW-1:0]   wr_id;
  logic [BramAw-1:0]   wr_addr;

  rd_state_t           rd_st;
  logic [AxiIdW-1:0]   rd_id;
  logic [AxiLenW-1:0]  rd_len;
  logic [AxiLenW:0]    rd_cnt;
  logic [BramAw-1:0]   rd_addr;
  logic                pend;
  logic                p_last;
  logic                slot_v;
  logic                slot_last;
  logic [AxiDataW-1:0] slot_d;
  logic                drain;
  logic                slot_free;
  logic                accept;
  logic                replay;
  logic                issue;

  assign s_awready = (wr_st == WR_IDLE);
  assign s_wready  = (wr_st == WR_DATA);
  assign s_bvalid  = (wr_st == WR_RESP);
  assign s_bid     = wr_id;
  assign s_bresp   = RespOkay;

  // Port A writes on the W handshake itself
  assign ena     = s_wready && s_wvalid;
  assign wrena   = ena;
  assign rdena   = 1'b0;
  assign byteena = s_wstrb;
  assign addra   = wr_addr;
  assign dina    = s_wdata;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_st <= WR_IDLE;
    end else begin
      case (wr_st)
        WR_IDLE: if (s_awvalid) wr_st <= WR_DATA;
        WR_DATA: if (s_wvalid && s_wlast) wr_st <= WR_RESP;
        WR_RESP: if (s_bready) wr_st <= WR_IDLE;
        default: wr_st <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_awready && s_awvalid) begin
      wr_id   <= s_awid;
      wr_addr <= s_awaddr[BramAw+2:3];
    end else if (ena) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  assign drain     = slot_v && s_rready;
  assign slot_free = !slot_v || drain;
  assign accept    = pend && slot_free;
  // Slot still held, so the word in flight is fetched again
  assign replay    = pend && !slot_free;
  assign issue     = (rd_st == RD_BURST) && (rd_cnt <= {1'b0, rd_len}) && slot_free;

  // rd_addr points at the next new word
  assign enb     = issue || replay;
  assign rdenb   = enb;
  assign wrenb   = 1'b0;
  assign byteenb = '1;
  assign addrb   = replay ? rd_addr - 1'b1 : rd_addr;
  assign dinb    = '0;

  assign s_arready = (rd_st == RD_IDLE);
  assign s_rvalid  = slot_v;
  assign s_rdata   = slot_d;
  assign s_rlast   = slot_last;
  assign s_rid     = rd_id;
  assign s_rresp   = RespOkay;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_st     <= RD_IDLE;
      pend      <= 1'b0;
      slot_v    <= 1'b0;
      slot_last <= 1'b0;
    end else begin
      pend <= issue || replay;
      if (accept) begin
        slot_v    <= 1'b1;
        slot_last <= p_last;
      end else if (drain) begin
        slot_v <= 1'b0;
      end
      case (rd_st)
        RD_IDLE:  if (s_arvalid) rd_st <= RD_BURST;
        RD_BURST: if (drain && slot_last) rd_st <= RD_IDLE;
        default:  rd_st <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_arready && s_arvalid) begin
      rd_id   <= s_arid;
      rd_len  <= s_arlen;
      rd_addr <= s_araddr[BramAw+2:3];
      rd_cnt  <= '0;
    end else if (issue) begin
      rd_addr <= rd_addr + 1'b1;
      rd_cnt  <= rd_cnt + 1'b1;
      p_last  <= (rd_cnt == {1'b0, rd_len});
    end
    if (accept) begin
      slot_d <= doutb;
    end
  end

endmodule

// File: design/top_level.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory slice, manager ports through
// the arbiter and controller to BRAM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module top_level #(
  parameter int NM     = 2,
  parameter int BramAw = 10
) (
  input  logic                              clk,
  input  logic                              rst_n,
  // Manager ports, manager 0 in the low slice
  input  logic [NM*defs_pkg::AxiIdW-1:0]   s_awid,
  input  logic [NM*defs_pkg::AxiAddrW-1:0] s_awaddr,
  input  logic [NM*defs_pkg::AxiLenW-1:0]  s_awlen,
  input  logic [NM-1:0]                    s_awvalid,
  output logic [NM-1:0]                    s_awready,
  input  logic [NM*defs_pkg::AxiDataW-1:0] s_wdata,
  input  logic [NM*defs_pkg::AxiStrbW-1:0] s_wstrb,
  input  logic [NM-1:0]                    s_wlast,
  input  logic [NM-1:0]                    s_wvalid,
  output logic [NM-1:0]                    s_wready,
  output logic [NM*defs_pkg::AxiIdW-1:0]   s_bid,
  output logic [NM*2-1:0]                  s_bresp,
  output logic [NM-1:0]                    s_bvalid,
  input  logic [NM-1:0]                    s_bready,
  input  logic [NM*defs_pkg::AxiIdW-1:0]   s_arid,
  input  logic [NM*defs_pkg::AxiAddrW-1:0] s_araddr,
  input  logic [NM*defs_pkg::AxiLenW-1:0]  s_arlen,
  input  logic [NM-1:0]                    s_arvalid,
  output logic [NM-1:0]                    s_arready,
  output logic [NM*defs_pkg::AxiIdW-1:0]   s_rid,
  output logic [NM*defs_pkg::AxiDataW-1:0] s_rdata,
  output logic [NM*2-1:0]                  s_rresp,
  output logic [NM-1:0]                    s_rlast,
  output logic [NM-1:0]                    s_rvalid,
  input  logic [NM-1:0]                    s_rready,
  // BRAM port A
  output logic                             ena,
  output logic                             rdena,
  output logic                             wrena,
  output logic [defs_pkg::AxiStrbW-1:0]    byteena,
  output logic [BramAw-1:0]                addra,
  output logic [defs_pkg::AxiDataW-1:0]    dina,
  input  logic [defs_pkg::AxiDataW-1:0]    douta,
  // BRAM port B
  output logic                             enb,
  output logic                             rdenb,
  output logic                             wrenb,
  output logic [defs_pkg::AxiStrbW-1:0]    byteenb,
  output logic [BramAw-1:0]                addrb,
  output logic [defs_pkg::AxiDataW-1:0]    dinb,
  input  logic [defs_pkg::AxiDataW-1:0]    doutb
);

  import defs_pkg::*;

  // Arbiter to controller
  logic [AxiIdW-1:0]   m_awid;
  logic [AxiAddrW-1:0] m_awaddr;
  logic [AxiLenW-1:0]  m_awlen;
  logic                m_awvalid;
  logic                m_awready;
  logic [AxiDataW-1:0] m_wdata;
  logic [AxiStrbW-1:0] m_wstrb;
  logic                m_wlast;
  logic                m_wvalid;
  logic                m_wready;
  logic [AxiIdW-1:0]   m_bid;
  logic [1:0]          m_bresp;
  logic                m_bvalid;
  logic                m_bready;
  logic [AxiIdW-1:0]   m_arid;
  logic [AxiAddrW-1:0] m_araddr;
  logic [AxiLenW-1:0]  m_arlen;
  logic                m_arvalid;
  logic                m_arready;
  logic [AxiIdW-1:0]   m_rid;
  logic [AxiDataW-1:0] m_rdata;
  logic [1:0]          m_rresp;
  logic                m_rlast;
  logic                m_rvalid;
  logic                m_rready;

  axi_arbiter #(
    .NM(NM)
  ) axi_arbiter_0 (.*);

  ssram_ctrl #(
    .BramAw(BramAw)
  ) ssram_ctrl_0 (
    .s_awid   (m_awid),
    .s_awaddr (m_awaddr),
    .s_awlen  (m_awlen),
    .s_awvalid(m_awvalid),
    .s_awready(m_awready),
    .s_wdata  (m_wdata),
    .s_wstrb  (m_wstrb),
    .s_wlast  (m_wlast),
    .s_wvalid (m_wvalid),
    .s_wready (m_wready),
    .s_bid    (m_bid),
    .s_bresp  (m_bresp),
    .s_bvalid (m_bvalid),
    .s_bready (m_bready),
    .s_arid   (m_arid),
    .s_araddr (m_araddr),
    .s_arlen  (m_arlen),
    .s_arvalid(m_arvalid),
    .s_arready(m_arready),
    .s_rid    (m_rid),
    .s_rdata  (m_rdata),
    .s_rresp  (m_rresp),
    .s_rlast  (m_rlast),
    .s_rvalid (m_rvalid),
    .s_rready (m_rready),
    .*
  );

endmodule

// File: tb/bram_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-port 64-bit BRAM model, byte
// enables, one-cycle read latency
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bram_model #(
  parameter int Aw = 10
) (
  input  logic          clk,
  input  logic          ena,
  input  logic          rdena,
  input  logic          wrena,
  input  logic [7:0]    byteena,
  input  logic [Aw-1:0] addra,
  input  logic [63:0]   dina,
  output logic [63:0]   douta,
  input  logic          enb,
  input  logic          rdenb,
  input  logic          wrenb,
  input  logic [7:0]    byteenb,
  input  logic [Aw-1:0] addrb,
  input  logic [63:0]   dinb,
  output logic [63:0]   doutb
);

  logic [63:0] mem [0:(1<<Aw)-1];

  // Power-up content follows the word address
  initial begin
    logic [31:0] a;
    for (int i = 0; i < (1 << Aw); i++) begin
      a = i;
      mem[i] = {~a, a ^ 32'h5a5a_5a5a};
    end
    douta = '0;
    doutb = '0;
  end

  always @(posedge clk) begin
    for (int b = 0; b < 8; b++) begin
      if (ena && wrena && byteena[b]) begin
        mem[addra][8*b +: 8] <= dina[8*b +: 8];
      end
      if (enb && wrenb && byteenb[b]) begin
        mem[addrb][8*b +: 8] <= dinb[8*b +: 8];
      end
    end
    if (ena && rdena) begin
      douta <= mem[addra];
    end
    if (enb && rdenb) begin
      doutb <= mem[addrb];
    end
  end

endmodule

// File: tb/top_level_chk.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Handshake, grant and BRAM write
// assertions bound to top_level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module top_level_chk #(
  parameter int NM = 2
) (
  input logic          clk,
  input logic          rst_n,
  input logic [NM-1:0] s_awready,
  input logic [NM-1:0] s_arready,
  input logic [NM-1:0] s_wvalid,
  input logic [NM-1:0] s_wready,
  input logic          m_awvalid,
  input logic          m_awready,
  input logic          m_wvalid,
  input logic          m_wready,
  input logic          m_bvalid,
  input logic          m_bready,
  input logic          m_arvalid,
  input logic          m_arready,
  input logic          m_rvalid,
  input logic          m_rready,
  input logic          ena,
  input logic          wrena
);

  property valid_held(logic v, logic r);
    @(posedge clk) disable iff (!rst_n) (v && !r) |=> v;
  endproperty

  aw_held: assert property (valid_held(m_awvalid, m_awready))
    else $error("AW valid dropped before it was accepted");
  w_held: assert property (valid_held(m_wvalid, m_wready))
    else $error("W valid dropped before it was accepted");
  b_held: assert property (valid_held(m_bvalid, m_bready))
    else $error("B valid dropped before it was accepted");
  ar_held: assert property (valid_held(m_arvalid, m_arready))
    else $error("AR valid dropped before it was accepted");
  r_held: assert property (valid_held(m_rvalid, m_rready))
    else $error("R valid dropped before it was accepted");

  // One grant per direction
  aw_one: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(s_awready))
    else $error("awready raised for more than one manager");
  ar_one: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(s_arready))
    else $error("arready raised for more than one manager");

  // A manager W beat always lands as a port A write
  a_write: assert property (@(posedge clk) disable iff (!rst_n)
    (s_wvalid & s_wready) != '0 |-> ena && wrena)
    else $error("W beat accepted while port A wrena is low");

endmodule

bind top_level top_level_chk #(
  .NM(NM)
) chk_0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .s_awready(s_awready),
  .s_arready(s_arready),
  .s_wvalid (s_wvalid),
  .s_wready (s_wready),
  .m_awvalid(m_awvalid),
  .m_awready(m_awready),
  .m_wvalid (m_wvalid),
  .m_wready (m_wready),
  .m_bvalid (m_bvalid),
  .m_bready (m_bready),
  .m_arvalid(m_arvalid),
  .m_arready(m_arready),
  .m_rvalid (m_rvalid),
  .m_rready (m_rready),
  .ena      (ena),
  .wrena    (wrena)
);

// File: tb/tb_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for top_level with an operation
// table, AXI4 driver tasks and a ref memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_top;

  import defs_pkg::*;

  localparam int          NM       = 2;
  localparam int          BramAw   = 10;
  localparam int          Words    = 1 << BramAw;
  localparam int          NumOps   = 31;
  localparam int          Timeout  = 200;
  localparam logic [31:0] Seed     = 32'h5771;
  localparam logic [1:0]  OkayResp = 2'b00;
  localparam int          ChAw     = 0;
  localparam int          ChW      = 1;
  localparam int          ChAr     = 2;

  typedef struct packed {
    logic        mgr;
    logic        wr;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [7:0]  strb;
    logic        bp;
    logic        with_next;
  } op_t;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic [NM*AxiIdW-1:0]     s_awid;
  logic [NM*AxiAddrW-1:0]   s_awaddr;
  logic [NM*AxiLenW-1:0]    s_awlen;
  logic [NM-1:0]            s_awvalid;
  logic [NM-1:0]            s_awready;
  logic [NM*AxiDataW-1:0]   s_wdata;
  logic [NM*AxiStrbW-1:0]   s_wstrb;
  logic [NM-1:0]            s_wlast;
  logic [NM-1:0]            s_wvalid;
  logic [NM-1:0]            s_wready;
  logic [NM*AxiIdW-1:0]     s_bid;
  logic [NM*2-1:0]          s_bresp;
  logic [NM-1:0]            s_bvalid;
  logic [NM-1:0]            s_bready;
  logic [NM*AxiIdW-1:0]     s_arid;
  logic [NM*AxiAddrW-1:0]   s_araddr;
  logic [NM*AxiLenW-1:0]    s_arlen;
  logic [NM-1:0]            s_arvalid;
  logic [NM-1:0]            s_arready;
  logic [NM*AxiIdW-1:0]     s_rid;
  logic [NM*AxiDataW-1:0]   s_rdata;
  logic [NM*2-1:0]          s_rresp;
  logic [NM-1:0]            s_rlast;
  logic [NM-1:0]            s_rvalid;
  logic [NM-1:0]            s_rready;
  logic                     ena;
  logic                     rdena;
  logic                     wrena;
  logic [AxiStrbW-1:0]      byteena;
  logic [BramAw-1:0]        addra;
  logic [AxiDataW-1:0]      dina;
  logic [AxiDataW-1:0]      douta;
  logic                     enb;
  logic                     rdenb;
  logic                     wrenb;
  logic [AxiStrbW-1:0]      byteenb;
  logic [BramAw-1:0]        addrb;
  logic [AxiDataW-1:0]      dinb;
  logic [AxiDataW-1:0]      doutb;

  logic [31:0] lfsr_q = Seed;
  logic [63:0] ref_mem [0:Words-1];
  op_t         ops [NumOps];
  int          errors = 0;
  int          checks = 0;

  always #5 clk = ~clk;

  top_level #(
    .NM    (NM),
    .BramAw(BramAw)
  ) DUT (.*);

  bram_model #(
    .Aw(BramAw)
  ) bram_0 (.*);

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] rand_word();
    logic [63:0] w;
    for (int k = 0; k < 64; k++) begin
      w[k] = next_bit();
    end
    return w;
  endfunction

  function automatic op_t row(input logic mgr, input logic wr, input logic [31:0] addr,
                              input logic [7:0] len, input logic [7:0] strb,
                              input logic bp, input logic with_next);
    return '{mgr, wr, addr, len, strb, bp, with_next};
  endfunction

  // Word index from address bits [BramAw+2:3] that wraps per beat
  function automatic int word_of(input logic [31:0] addr, input int beat);
    return (int'(addr[BramAw+2:3]) + beat) % Words;
  endfunction

  function automatic logic ready_of(input int ch, input int m);
    case (ch)
      ChAw:    return s_awready[m];
      ChW:     return s_wready[m];
      default: return s_arready[m];
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("Timeout at %0t: %s", $time, what);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic wait_ready(input int ch, input int m, input string what);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!ready_of(ch, m) && cnt < Timeout) begin
      @(negedge clk);
      cnt++;
    end
    if (!ready_of(ch, m)) abort_run($sformatf("%s of manager %0d never came", what, m));
  endtask

  task automatic write_op(input op_t op, input logic [3:0] id);
    int          m;
    int          len;
    int          cnt;
    int          w;
    logic        done;
    logic [63:0] data;
    m   = int'(op.mgr);
    len = int'(op.len);
    @(posedge clk);
    s_awid[m*AxiIdW +: AxiIdW]       <= id;
    s_awaddr[m*AxiAddrW +: AxiAddrW] <= op.addr;
    s_awlen[m*AxiLenW +: AxiLenW]    <= op.len;
    s_awvalid[m]                     <= 1'b1;
    wait_ready(ChAw, m, "AW handshake");
    @(posedge clk);
    s_awvalid[m] <= 1'b0;
    for (int beat = 0; beat <= len; beat++) begin
      data = rand_word();
      s_wdata[m*AxiDataW +: AxiDataW] <= data;
      s_wstrb[m*AxiStrbW +: AxiStrbW] <= op.strb;
      s_wlast[m]                      <= (beat == len);
      s_wvalid[m]                     <= 1'b1;
      wait_ready(ChW, m, "W handshake");
      w = word_of(op.addr, beat);
      for (int b = 0; b < 8; b++) begin
        if (op.strb[b]) ref_mem[w][8*b +: 8] = data[8*b +: 8];
      end
      @(posedge clk);
    end
    s_wvalid[m] <= 1'b0;
    s_wlast[m]  <= 1'b0;
    s_bready[m] <= op.bp ? next_bit() : 1'b1;
    done = 1'b0;
    cnt  = 0;
    while (!done && cnt < Timeout) begin
      @(negedge clk);
      cnt++;
      if (s_bvalid[m] && s_bready[m]) begin
        checks++;
        done = 1'b1;
        if (s_bid[m*AxiIdW +: AxiIdW] != id || s_bresp[m*2 +: 2] != OkayResp) begin
          report_mismatch($sformatf("manager %0d B: id %h resp %b, expected id %h OKAY",
                                    m, s_bid[m*AxiIdW +: AxiIdW], s_bresp[m*2 +: 2], id));
        end
      end
      @(posedge clk);
      s_bready[m] <= done ? 1'b0 : (op.bp ? next_bit() : 1'b1);
    end
    if (!done) abort_run($sformatf("B response of manager %0d never came", m));
  endtask

  task automatic read_op(input op_t op, input logic [3:0] id);
    int          m;
    int          len;
    int          beat;
    int          cnt;
    logic        done;
    logic [63:0] exp;
    m   = int'(op.mgr);
    len = int'(op.len);
    @(posedge clk);
    s_arid[m*AxiIdW +: AxiIdW]       <= id;
    s_araddr[m*AxiAddrW +: AxiAddrW] <= op.addr;
    s_arlen[m*AxiLenW +: AxiLenW]    <= op.len;
    s_arvalid[m]                     <= 1'b1;
    wait_ready(ChAr, m, "AR handshake");
    @(posedge clk);
    s_arvalid[m] <= 1'b0;
    s_rready[m]  <= op.bp ? next_bit() : 1'b1;
    beat = 0;
    cnt  = 0;
    done = 1'b0;
    while (!done && cnt < Timeout) begin
      @(negedge clk);
      cnt++;
      if (s_rvalid[m] && s_rready[m]) begin
        checks++;
        exp = ref_mem[word_of(op.addr, beat)];
        if (s_rdata[m*AxiDataW +: AxiDataW] != exp) begin
          report_mismatch($sformatf("manager %0d read beat %0d: data %h, expected %h",
                                    m, beat, s_rdata[m*AxiDataW +: AxiDataW], exp));
        end
        if (s_rid[m*AxiIdW +: AxiIdW] != id || s_rresp[m*2 +: 2] != OkayResp) begin
          report_mismatch($sformatf("manager %0d read beat %0d: id %h resp %b, expected id %h",
                                    m, beat, s_rid[m*AxiIdW +: AxiIdW], s_rresp[m*2 +: 2], id));
        end
        if (s_rlast[m] != (beat == len)) begin
          report_mismatch($sformatf("manager %0d read beat %0d of %0d: rlast %b",
                                    m, beat, len, s_rlast[m]));
        end
        done = (beat == len);
        beat++;
      end
      @(posedge clk);
      s_rready[m] <= done ? 1'b0 : (op.bp ? next_bit() : 1'b1);
    end
    if (!done) abort_run($sformatf("read burst of manager %0d stalled at beat %0d", m, beat));
  endtask

  task automatic run_op(input int idx);
    if (ops[idx].wr) begin
      write_op(ops[idx], 4'(idx));
    end else begin
      read_op(ops[idx], 4'(idx));
    end
  endtask

  initial begin
    int          i;
    logic [31:0] a;
    rst_n     = 1'b0;
    s_awid    = '0;
    s_awaddr  = '0;
    s_awlen   = '0;
    s_awvalid = '0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wlast   = '0;
    s_wvalid  = '0;
    s_bready  = '0;
    s_arid    = '0;
    s_araddr  = '0;
    s_arlen   = '0;
    s_arvalid = '0;
    s_rready  = '0;
    for (int k = 0; k < Words; k++) begin
      a = k;
      ref_mem[k] = {~a, a ^ 32'h5a5a_5a5a};
    end

    // mgr, write, address, length, strobe, back-pressure, run with next row
    ops[0]  = row(1'b0, 1'b1, 32'h0000_0040, 8'd0, 8'hff, 1'b0, 1'b0);
    ops[1]  = row(1'b0, 1'b0, 32'h0000_0040, 8'd0, 8'h00, 1'b0, 1'b0);
    // Partial strobes
    ops[2]  = row(1'b1, 1'b1, 32'h0000_0040, 8'd0, 8'h5a, 1'b0, 1'b0);
    ops[3]  = row(1'b1, 1'b0, 32'h0000_0040, 8'd0, 8'h00, 1'b0, 1'b0);
    ops[4]  = row(1'b0, 1'b1, 32'h0000_0048, 8'd1, 8'h81, 1'b0, 1'b0);
    ops[5]  = row(1'b0, 1'b0, 32'h0000_0048, 8'd1, 8'h00, 1'b0, 1'b0);
    // Burst lengths 0 to 7
    ops[6]  = row(1'b1, 1'b1, 32'h0000_0100, 8'd7, 8'hff, 1'b0, 1'b0);
    ops[7]  = row(1'b0, 1'b0, 32'h0000_0100, 8'd0, 8'h00, 1'b0, 1'b0);
    ops[8]  = row(1'b1, 1'b0, 32'h0000_0100, 8'd1, 8'h00, 1'b0, 1'b0);
    ops[9]  = row(1'b0, 1'b0, 32'h0000_0100, 8'd2, 8'h00, 1'b0, 1'b0);
    ops[10] = row(1'b1, 1'b0, 32'h0000_0100, 8'd3, 8'h00, 1'b0, 1'b0);
    ops[11] = row(1'b0, 1'b0, 32'h0000_0100, 8'd4, 8'h00, 1'b0, 1'b0);
    ops[12] = row(1'b1, 1'b0, 32'h0000_0100, 8'd5, 8'h00, 1'b0, 1'b0);
    ops[13] = row(1'b0, 1'b0, 32'h0000_0100, 8'd6, 8'h00, 1'b0, 1'b0);
    ops[14] = row(1'b1, 1'b0, 32'h0000_0100, 8'd7, 8'h00, 1'b0, 1'b0);
    // Random rready and bready
    ops[15] = row(1'b0, 1'b1, 32'h0000_0300, 8'd7, 8'hff, 1'b1, 1'b0);
    ops[16] = row(1'b1, 1'b0, 32'h0000_0300, 8'd7, 8'h00, 1'b1, 1'b0);
    ops[17] = row(1'b0, 1'b0, 32'h0000_0100, 8'd5, 8'h00, 1'b1, 1'b0);
    // Both managers at once
    ops[18] = row(1'b0, 1'b1, 32'h0000_0400, 8'd3, 8'hff, 1'b0, 1'b1);
    ops[19] = row(1'b1, 1'b1, 32'h0000_0500, 8'd2, 8'hff, 1'b0, 1'b0);
    ops[20] = row(1'b0, 1'b0, 32'h0000_0500, 8'd2, 8'h00, 1'b0, 1'b1);
    ops[21] = row(1'b1, 1'b0, 32'h0000_0400, 8'd3, 8'h00, 1'b0, 1'b0);
    ops[22] = row(1'b0, 1'b1, 32'h0000_0600, 8'd1, 8'hff, 1'b1, 1'b1);
    ops[23] = row(1'b1, 1'b0, 32'h0000_0300, 8'd7, 8'h00, 1'b1, 1'b0);
    ops[24] = row(1'b1, 1'b1, 32'h0000_0700, 8'd2, 8'hff, 1'b1, 1'b1);
    ops[25] = row(1'b0, 1'b0, 32'h0000_0600, 8'd1, 8'h00, 1'b1, 1'b0);
    // Addresses beyond the BRAM and a wrap at the top word
    ops[26] = row(1'b0, 1'b1, 32'h8000_2010, 8'd0, 8'hff, 1'b0, 1'b0);
    ops[27] = row(1'b1, 1'b0, 32'h0000_0010, 8'd0, 8'h00, 1'b0, 1'b0);
    ops[28] = row(1'b1, 1'b1, 32'h0000_1ff8, 8'd2, 8'hff, 1'b0, 1'b0);
    ops[29] = row(1'b0, 1'b0, 32'h0000_1ff8, 8'd2, 8'h00, 1'b0, 1'b0);
    ops[30] = row(1'b0, 1'b0, 32'h0000_0000, 8'd1, 8'h00, 1'b0, 1'b0);

    repeat (2) @(posedge clk);
    @(negedge clk);
    checks++;
    if (s_awready != '0 || s_arready != '0 || s_wready != '0 || s_bvalid != '0 ||
        s_rvalid != '0 || ena || rdena || wrena || enb || rdenb || wrenb) begin
      report_mismatch("outputs not idle during reset");
    end
    @(posedge clk);
    rst_n <= 1'b1;

    i = 0;
    while (i < NumOps) begin
      if (ops[i].with_next) begin
        fork
          run_op(i);
          run_op(i + 1);
        join
        i += 2;
      end else begin
        run_op(i);
        i++;
      end
    end

    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: all.f
design/defs_pkg.sv
design/axi_arbiter.sv
design/ssram_ctrl.sv
design/top_level.sv
tb/bram_model.sv
tb/top_level_chk.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# Build tb_top with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_top -f all.f -o sim_tb_top; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_top)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1
